//--- router_port_pkg.sv
package router_port_pkg;

  // Five router ports: four mesh neighbours and the local core
  localparam int NUM_PORTS = 5;

  // The same code indexes an input port and an output port
  typedef enum logic [2:0] {
    DIR_N = 3'd0,
    DIR_S = 3'd1,
    DIR_W = 3'd2,
    DIR_E = 3'd3,
    DIR_L = 3'd4
  } dir_e;

  // One mesh coordinate, which covers an 8 by 8 mesh
  localparam int COORD_W = 3;

  typedef logic [COORD_W-1:0] coord_t;

endpackage

//--- router_flit_pkg.sv
package router_flit_pkg;

  import router_port_pkg::*;

  // Every packet is a single flit of this width
  localparam int FLIT_W = 16;

  // Whatever the destination fields leave over
  localparam int PAYLOAD_W = FLIT_W - 2 * COORD_W;

  // Routing view, with the destination in the top bits
  typedef struct packed {
    coord_t                 dst_x;
    coord_t                 dst_y;
    logic [PAYLOAD_W-1:0]   payload;
  } flit_route_t;

  // The buffer decodes the route view, the crossbar only moves the raw word
  typedef union packed {
    flit_route_t            route;
    logic [FLIT_W-1:0]      raw;
  } flit_u;

endpackage

//--- route_req_if.sv
`timescale 1ns/1ps

interface route_req_if import router_port_pkg::*, router_flit_pkg::*; ();

  // Head flit of one input buffer and the output it asks for
  flit_u flit;
  dir_e  req_dir;
  logic  req_valid;

  // Single cycle pulse back to the buffer when its head flit won an output
  logic  grant;

  modport buffer (output flit, output req_dir, output req_valid, input grant);

  modport arbiter (input req_dir, input req_valid);

  modport xbar (input flit, input req_valid, output grant);

endinterface

//--- input_buffer.sv
`timescale 1ns/1ps

module input_buffer import router_port_pkg::*, router_flit_pkg::*; #(
  parameter coord_t ROUTER_X   = 3'd0,
  parameter coord_t ROUTER_Y   = 3'd0,
  parameter int     FIFO_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  flit_u       data_i,
  input  logic        valid_i,
  output logic        full_o,
  route_req_if.buffer req
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  flit_u            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  flit_u            head;
  dir_e             route_dir;

  assign full_o = (count == CNT_W'(FIFO_DEPTH));
  assign push   = valid_i && !full_o;
  // The crossbar only grants a buffer that is requesting
  assign pop    = req.grant;

  // Flit storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head = mem[rd_ptr];

  // XY routing resolves the X offset before looking at Y
  always_comb begin
    if (head.route.dst_x > ROUTER_X) begin
      route_dir = DIR_E;
    end else if (head.route.dst_x < ROUTER_X) begin
      route_dir = DIR_W;
    end else if (head.route.dst_y > ROUTER_Y) begin
      route_dir = DIR_N;
    end else if (head.route.dst_y < ROUTER_Y) begin
      route_dir = DIR_S;
    end else begin
      route_dir = DIR_L;
    end
  end

  // Head flit and request stay put until the grant edge
  assign req.flit      = head;
  assign req.req_dir   = route_dir;
  assign req.req_valid = (count != '0);

endmodule

//--- rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter import router_port_pkg::*; #(
  parameter dir_e OUT_DIR = DIR_N
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  route_req_if.arbiter         reqs [NUM_PORTS],
  output logic [NUM_PORTS-1:0] grant_o
);

  localparam int IDX_W = $clog2(NUM_PORTS);

  logic [NUM_PORTS-1:0] eligible;
  logic [IDX_W-1:0]     ptr;
  logic [IDX_W-1:0]     winner;

  // Only inputs whose head flit wants this output take part
  for (genvar gi = 0; gi < NUM_PORTS; gi++) begin : g_elig
    assign eligible[gi] = reqs[gi].req_valid && (reqs[gi].req_dir == OUT_DIR);
  end

  // First eligible input at or after the pointer wins
  always_comb begin
    int  idx;
    logic found;
    grant_o = '0;
    winner  = ptr;
    found   = 1'b0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      idx = int'(ptr) + k;
      if (idx >= NUM_PORTS) begin
        idx = idx - NUM_PORTS;
      end
      if (!found && eligible[idx]) begin
        grant_o[idx] = 1'b1;
        winner       = IDX_W'(idx);
        found        = 1'b1;
      end
    end
  end

  // The winner drops to lowest priority for the next round
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr <= IDX_W'(DIR_N);
    end else if (|grant_o) begin
      ptr <= (winner == IDX_W'(NUM_PORTS - 1)) ? '0 : winner + 1'b1;
    end
  end

endmodule

//--- crossbar_switch_inner.sv
`timescale 1ns/1ps

module crossbar_switch_inner import router_port_pkg::*, router_flit_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  route_req_if.xbar            ins      [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] grants_i [NUM_PORTS],
  output flit_u                data_o   [NUM_PORTS],
  output logic [NUM_PORTS-1:0] valid_o
);

  flit_u                in_flit  [NUM_PORTS];
  logic [NUM_PORTS-1:0] in_valid;
  // xfer[o][i] is set when input i moves its flit to output o this cycle
  logic [NUM_PORTS-1:0] xfer     [NUM_PORTS];
  logic [NUM_PORTS-1:0] out_busy;
  flit_u                sel_flit [NUM_PORTS];

  for (genvar gi = 0; gi < NUM_PORTS; gi++) begin : g_in
    assign in_flit[gi]  = ins[gi].flit;
    assign in_valid[gi] = ins[gi].req_valid;
  end

  // A flit never turns back out of the port it came in on
  for (genvar go = 0; go < NUM_PORTS; go++) begin : g_path
    for (genvar gi = 0; gi < NUM_PORTS; gi++) begin : g_src
      if (go == gi) begin : g_uturn
        assign xfer[go][gi] = 1'b0;
      end else begin : g_link
        assign xfer[go][gi] = grants_i[go][gi] && in_valid[gi];
      end
    end
  end

  // An input pops once whichever output took its flit
  for (genvar gi = 0; gi < NUM_PORTS; gi++) begin : g_demux
    logic hit;
    always_comb begin
      hit = 1'b0;
      for (int o = 0; o < NUM_PORTS; o++) begin
        hit = hit | xfer[o][gi];
      end
    end
    assign ins[gi].grant = hit;
  end

  // Grants are one-hot so at most one input matches on each output
  for (genvar go = 0; go < NUM_PORTS; go++) begin : g_mux
    always_comb begin
      sel_flit[go] = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (xfer[go][i]) begin
          sel_flit[go] = in_flit[i];
        end
      end
    end
    assign out_busy[go] = |xfer[go];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= '0;
    end else begin
      valid_o <= out_busy;
    end
  end

  // Output data only changes when a flit is actually delivered
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (out_busy[o]) begin
        data_o[o] <= sel_flit[o];
      end
    end
  end

endmodule

//--- mesh_router.sv
`timescale 1ns/1ps

module mesh_router import router_port_pkg::*, router_flit_pkg::*; #(
  parameter coord_t ROUTER_X   = 3'd0,
  parameter coord_t ROUTER_Y   = 3'd0,
  parameter int     FIFO_DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [FLIT_W-1:0] n_data_i,
  input  logic              n_valid_i,
  output logic              n_full_o,
  output logic [FLIT_W-1:0] n_data_o,
  output logic              n_valid_o,
  input  logic [FLIT_W-1:0] s_data_i,
  input  logic              s_valid_i,
  output logic              s_full_o,
  output logic [FLIT_W-1:0] s_data_o,
  output logic              s_valid_o,
  input  logic [FLIT_W-1:0] w_data_i,
  input  logic              w_valid_i,
  output logic              w_full_o,
  output logic [FLIT_W-1:0] w_data_o,
  output logic              w_valid_o,
  input  logic [FLIT_W-1:0] e_data_i,
  input  logic              e_valid_i,
  output logic              e_full_o,
  output logic [FLIT_W-1:0] e_data_o,
  output logic              e_valid_o,
  input  logic [FLIT_W-1:0] l_data_i,
  input  logic              l_valid_i,
  output logic              l_full_o,
  output logic [FLIT_W-1:0] l_data_o,
  output logic              l_valid_o
);

  flit_u                in_data   [NUM_PORTS];
  logic [NUM_PORTS-1:0] in_valid;
  logic [NUM_PORTS-1:0] in_full;
  logic [NUM_PORTS-1:0] arb_grant [NUM_PORTS];
  flit_u                out_data  [NUM_PORTS];
  logic [NUM_PORTS-1:0] out_valid;

  route_req_if req_if [NUM_PORTS] ();

  // Named ports onto the direction-indexed arrays
  assign in_data[DIR_N] = n_data_i;
  assign in_data[DIR_S] = s_data_i;
  assign in_data[DIR_W] = w_data_i;
  assign in_data[DIR_E] = e_data_i;
  assign in_data[DIR_L] = l_data_i;

  assign in_valid = {l_valid_i, e_valid_i, w_valid_i, s_valid_i, n_valid_i};

  assign n_full_o = in_full[DIR_N];
  assign s_full_o = in_full[DIR_S];
  assign w_full_o = in_full[DIR_W];
  assign e_full_o = in_full[DIR_E];
  assign l_full_o = in_full[DIR_L];

  // Index g is the input port for the buffer and the output port for the arbiter
  for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
    input_buffer #(
      .ROUTER_X   (ROUTER_X),
      .ROUTER_Y   (ROUTER_Y),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_buf (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (in_data[g]),
      .valid_i (in_valid[g]),
      .full_o  (in_full[g]),
      .req     (req_if[g])
    );

    rr_arbiter #(
      .OUT_DIR (dir_e'(g))
    ) u_arb (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .reqs    (req_if),
      .grant_o (arb_grant[g])
    );
  end

  crossbar_switch_inner u_xbar (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .ins      (req_if),
    .grants_i (arb_grant),
    .data_o   (out_data),
    .valid_o  (out_valid)
  );

  assign n_data_o  = out_data[DIR_N].raw;
  assign s_data_o  = out_data[DIR_S].raw;
  assign w_data_o  = out_data[DIR_W].raw;
  assign e_data_o  = out_data[DIR_E].raw;
  assign l_data_o  = out_data[DIR_L].raw;

  assign n_valid_o = out_valid[DIR_N];
  assign s_valid_o = out_valid[DIR_S];
  assign w_valid_o = out_valid[DIR_W];
  assign e_valid_o = out_valid[DIR_E];
  assign l_valid_o = out_valid[DIR_L];

endmodule

//--- mesh_router_assertions.sv
`timescale 1ns/1ps

module mesh_router_assertions import router_port_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic [NUM_PORTS-1:0] grant_i,
  input logic [NUM_PORTS-1:0] req_i,
  input logic [NUM_PORTS-1:0] valid_i,
  input logic [NUM_PORTS-1:0] full_i
);

  // An output serves at most one input per cycle
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(grant_i))
    else $error("Arbiter grant is not one-hot");

  a_grant_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
    (grant_i & ~req_i) == '0)
    else $error("Grant given to an input that does not request this output");

  a_quiet_after_reset: assert property (@(posedge clk_i) rst_i |=> valid_i == '0)
    else $error("Output valid high in the cycle after reset");

  // A buffer only leaves the full state when its head flit reached an output register
  for (genvar gi = 0; gi < NUM_PORTS; gi++) begin : g_full
    a_full_falls_on_pop: assert property (@(posedge clk_i) disable iff (rst_i)
      $fell(full_i[gi]) |-> valid_i != '0)
      else $error("Input full level fell without a pop");
  end

endmodule

bind rr_arbiter mesh_router_assertions u_arb_assert (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .grant_i (grant_o),
  .req_i   (eligible),
  .valid_i ('0),
  .full_i  ('0)
);

bind mesh_router mesh_router_assertions u_router_assert (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .grant_i ('0),
  .req_i   ('0),
  .valid_i (out_valid),
  .full_i  (in_full)
);

//--- tb_mesh_router.sv
`timescale 1ns/1ps

module tb_mesh_router import router_port_pkg::*, router_flit_pkg::*; ();

  localparam coord_t ROUTER_X   = 3'd2;
  localparam coord_t ROUTER_Y   = 3'd2;
  localparam int     FIFO_DEPTH = 4;
  localparam int     DRIVE_DLY  = 2;

  logic                 clk_i;
  logic                 rst_i;
  logic [FLIT_W-1:0]    din  [NUM_PORTS];
  logic [NUM_PORTS-1:0] vin;
  wire  [FLIT_W-1:0]    dout [NUM_PORTS];
  wire  [NUM_PORTS-1:0] vout;
  wire  [NUM_PORTS-1:0] full;

  // Flits still owed by each output, oldest first
  flit_u exp_q [NUM_PORTS][$];
  // Cycle in which each entry of exp_q was driven, kept in step with it
  int    exp_cyc [NUM_PORTS][$];
  // Input that the previous flit on each output came from, -1 before the first
  int    last_src [NUM_PORTS];
  int    cyc          = 0;
  int    mismatches   = 0;
  int    misroutes    = 0;
  int    unfair       = 0;
  int    timeouts     = 0;
  int    setup_errors = 0;

  mesh_router #(
    .ROUTER_X   (ROUTER_X),
    .ROUTER_Y   (ROUTER_Y),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut0 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .n_data_i (din[DIR_N]), .n_valid_i (vin[DIR_N]), .n_full_o (full[DIR_N]),
    .n_data_o (dout[DIR_N]), .n_valid_o (vout[DIR_N]),
    .s_data_i (din[DIR_S]), .s_valid_i (vin[DIR_S]), .s_full_o (full[DIR_S]),
    .s_data_o (dout[DIR_S]), .s_valid_o (vout[DIR_S]),
    .w_data_i (din[DIR_W]), .w_valid_i (vin[DIR_W]), .w_full_o (full[DIR_W]),
    .w_data_o (dout[DIR_W]), .w_valid_o (vout[DIR_W]),
    .e_data_i (din[DIR_E]), .e_valid_i (vin[DIR_E]), .e_full_o (full[DIR_E]),
    .e_data_o (dout[DIR_E]), .e_valid_o (vout[DIR_E]),
    .l_data_i (din[DIR_L]), .l_valid_i (vin[DIR_L]), .l_full_o (full[DIR_L]),
    .l_data_o (dout[DIR_L]), .l_valid_o (vout[DIR_L])
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc++;
  end

  // The X offset is resolved before Y and a flit for this router goes to the local port
  function automatic dir_e xy_route(input flit_u f);
    if (f.route.dst_x > ROUTER_X)
      return DIR_E;
    else if (f.route.dst_x < ROUTER_X)
      return DIR_W;
    else if (f.route.dst_y > ROUTER_Y)
      return DIR_N;
    else if (f.route.dst_y < ROUTER_Y)
      return DIR_S;
    return DIR_L;
  endfunction

  // The top payload bits name the input port the flit entered on
  function automatic logic [2:0] src_of(input flit_u f);
    return f.route.payload[PAYLOAD_W-1 -: 3];
  endfunction

  function automatic int pending();
    int total;
    total = 0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      total += exp_q[o].size();
    end
    return total;
  endfunction

  // The oldest flit an input still holds sits at the head of its buffer
  function automatic int head_cycle(input int src, output int head_out);
    int best;
    best     = -1;
    head_out = -1;
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int k = 0; k < exp_q[o].size(); k++) begin
        if (src_of(exp_q[o][k]) == src && (best < 0 || exp_cyc[o][k] < best)) begin
          best     = exp_cyc[o][k];
          head_out = o;
        end
      end
    end
    return best;
  endfunction

  task automatic check_flit(input flit_u got, input flit_u exp, input dir_e port);
    if (got.raw !== exp.raw) begin
      mismatches++;
      $display("[ERROR] %0t: output %s gave flit %h, expected %h",
               $time, port.name(), got.raw, exp.raw);
    end
  endtask

  task automatic check_port(input dir_e got, input dir_e exp, input flit_u f);
    if (got !== exp) begin
      misroutes++;
      $display("[ERROR] %0t: flit %h left on output %s, expected output %s",
               $time, f.raw, got.name(), exp.name());
    end
  endtask

  task automatic check_bits(input logic [NUM_PORTS-1:0] got,
                            input logic [NUM_PORTS-1:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // An input that an output just served loses to any other input already waiting for it
  task automatic check_fair(input dir_e port, input logic [FLIT_W-1:0] word);
    flit_u f;
    dir_e  src;
    dir_e  other;
    int    t;
    int    head_out;
    f.raw = word;
    src   = dir_e'(src_of(f));
    if (last_src[port] == int'(src)) begin
      for (int r = 0; r < NUM_PORTS; r++) begin
        other = dir_e'(r);
        t     = head_cycle(r, head_out);
        if (r != int'(src) && head_out == int'(port) && t >= 0 && t <= cyc - 2) begin
          unfair++;
          $display("[ERROR] %0t: output %s served input %s twice while input %s waited",
                   $time, port.name(), src.name(), other.name());
        end
      end
    end
    last_src[port] = int'(src);
  endtask

  // Match against the oldest outstanding flit from the same source on this output
  task automatic take_flit(input dir_e port, input logic [FLIT_W-1:0] word);
    flit_u got;
    dir_e  want;
    int    hit;
    got.raw = word;
    want    = xy_route(got);
    hit     = -1;
    check_port(port, want, got);
    if (port == want) begin
      for (int k = 0; k < exp_q[port].size(); k++) begin
        if (hit < 0 && src_of(exp_q[port][k]) == src_of(got)) begin
          hit = k;
        end
      end
      if (hit < 0) begin
        mismatches++;
        $display("[ERROR] %0t: unexpected flit %h on output %s", $time, word, port.name());
      end else begin
        check_flit(got, exp_q[port][hit], port);
        exp_q[port].delete(hit);
        exp_cyc[port].delete(hit);
      end
    end
  endtask

  // Registered outputs have settled by the falling edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      // Arbitration is judged on the buffer contents before this cycle's deliveries
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (vout[o]) begin
          check_fair(dir_e'(o), dout[o]);
        end
      end
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (vout[o]) begin
          take_flit(dir_e'(o), dout[o]);
        end
      end
    end
  end

  task automatic finish_run();
    $display("mismatches %0d, misroutes %0d, arbitration errors %0d, timeouts %0d, %s %0d",
             mismatches, misroutes, unfair, timeouts, "setup errors", setup_errors);
    if (mismatches + misroutes + unfair + timeouts + setup_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // Valid strobes last one cycle, so they drop after every edge
  task automatic next_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
    vin = '0;
  endtask

  task automatic wait_not_full(input dir_e port, output bit ok);
    int n;
    n = 0;
    while (full[port] && n < 200) begin
      next_cycle();
      n++;
    end
    ok = !full[port];
    if (!ok) begin
      timeouts++;
      $display("Input %s stayed full for 200 cycles", port.name());
    end
  endtask

  task automatic inject(input dir_e port, input flit_u f, output bit ok);
    if (vin[port]) begin
      next_cycle();
    end
    wait_not_full(port, ok);
    if (ok) begin
      din[port] = f.raw;
      vin[port] = 1'b1;
      exp_q[xy_route(f)].push_back(f);
      exp_cyc[xy_route(f)].push_back(cyc);
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          port;
    int          gap;
    int          dx;
    int          dy;
    int          pay;
    int          waited;
    bit          ok;
    string       line;
    flit_u       f;
    void'($urandom(32'h8db230d8));
    rst_i = 1'b1;
    vin   = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      din[i]      = '0;
      last_src[i] = -1;
    end
    repeat (2) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;
    check_bits(vout, '0, "d_valid_o after reset");
    check_bits(full, '0, "d_full_o after reset");

    ok = 1'b1;
    fd = $fopen("router_stim.txt", "r");
    if (fd == 0) begin
      setup_errors++;
      $display("Could not open router_stim.txt for reading");
    end else begin
      while (ok && !$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %d %d %d %h", port, gap, dx, dy, pay);
          if (n == 5) begin
            // A negative gap asks for up to two extra idle cycles
            if (gap < 0) begin
              gap = -gap + int'($urandom % 3);
            end
            repeat (gap) next_cycle();
            f.route.dst_x   = coord_t'(dx);
            f.route.dst_y   = coord_t'(dy);
            f.route.payload = PAYLOAD_W'(pay);
            inject(dir_e'(port), f, ok);
          end
        end
      end
      $fclose(fd);
    end

    waited = 0;
    while (pending() != 0 && waited < 500) begin
      next_cycle();
      waited++;
    end
    if (pending() != 0) begin
      timeouts++;
      $display("Gave up after 500 cycles with %0d flits never delivered", pending());
    end
    // Leave room for a duplicated flit to show up
    repeat (4) next_cycle();
    finish_run();
  end

endmodule

//--- router_stim.txt
# port (0 N, 1 S, 2 W, 3 E, 4 L)  gap in cycles (negative adds 0 to 2)  dst_x  dst_y  payload hex
# payload[9:7] holds the source port and payload[6:0] a sequence number
0 3 5 2 001
0 3 0 2 002
1 3 2 5 081
1 -2 2 2 082
2 3 6 6 101
2 3 2 0 102
3 -2 1 4 181
3 3 2 7 182
4 3 2 1 201
4 3 3 0 202
0 4 2 2 003
1 0 2 2 083
2 0 7 3 103
3 0 0 1 183
0 1 2 2 004
1 0 2 2 084
2 0 5 2 104
3 0 1 2 184
0 1 2 2 005
1 0 2 2 085
2 0 4 0 105
3 0 0 6 185
2 6 2 6 106
3 0 2 6 186
2 1 2 6 107
3 0 2 6 187
2 1 2 6 108
3 0 2 6 188
2 1 2 6 109
3 0 2 6 189

//--- project.f
router_port_pkg.sv
router_flit_pkg.sv
route_req_if.sv
input_buffer.sv
rr_arbiter.sv
crossbar_switch_inner.sv
mesh_router.sv
mesh_router_assertions.sv
tb_mesh_router.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       ?= tb_mesh_router
FILELIST  ?= project.f
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
